/* Makefile */
# Verilator build for the execute pipeline testbench
VERILATOR ?= verilator
TOP       ?= exec_pipe_tb
FLIST     ?= exec_pipe.f
OBJ_DIR   ?= obj_dir
NUM_REGS  ?= 32
PASS_MSG  := Testbench passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run run16 clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GNUM_REGS=$(NUM_REGS) \
		-f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

# second build with the rv32e register count
run16:
	$(MAKE) clean
	$(MAKE) run NUM_REGS=16

clean:
	rm -rf $(OBJ_DIR)

/* exec_pipe.f */
source/rv_exec_pkg.sv
source/instr_accept.sv
source/instr_decode.sv
source/reg_file.sv
source/alu_exec.sv
source/exec_pipe.sv
sim/exec_pipe_checker.sv
sim/exec_pipe_tb.sv

/* sim/exec_pipe_checker.sv */
`timescale 1ns/100ps

module exec_pipe_checker
    import rv_exec_pkg::*;
(
    input logic            clk,
    input logic            rst,
    input logic            ins_req,
    input logic            ins_ack,
    input logic            acc_valid,
    input logic            dec_valid,
    input alu_op_t         dec_op,
    input logic [XLEN-1:0] dec_a,
    input logic [XLEN-1:0] dec_b,
    input logic            wb_valid,
    input logic            ins_illegal
);

    int fail_count = 0;     // assertion failures so far

    // ack only drops after req was seen low
    ack_fall_order: assert property (@(posedge clk) disable iff (rst)
        $fell(ins_ack) |-> !$past(ins_req))
        else
        begin
            $error("ack fell while req high");
            fail_count++;
        end

    ack_rise_order: assert property (@(posedge clk) disable iff (rst)
        $rose(ins_ack) |-> $past(ins_req))
        else
        begin
            $error("ack rose without req");
            fail_count++;
        end

    retire_or_illegal: assert property (@(posedge clk) disable iff (rst)
        !(wb_valid && ins_illegal))
        else
        begin
            $error("retire and illegal together");
            fail_count++;
        end

    // decoded payload must be known when valid
    dec_known: assert property (@(posedge clk) disable iff (rst)
        dec_valid |-> !$isunknown({dec_op, dec_a, dec_b}))
        else
        begin
            $error("unknown decode payload");
            fail_count++;
        end

    // illegal one edge earlier than retire
    accept_outcome: assert property (@(posedge clk) disable iff (rst)
        acc_valid |-> ##2 (wb_valid || $past(ins_illegal)))
        else
        begin
            $error("accepted request without outcome");
            fail_count++;
        end

endmodule : exec_pipe_checker

bind exec_pipe exec_pipe_checker u_checker (.*);

/* sim/exec_pipe_tb.sv */
`timescale 1ns/100ps

module exec_pipe_tb
    import rv_exec_pkg::*;
#(
    parameter int NUM_REGS = 32
);

    logic            clk;
    logic            rst;
    logic            ins_req;
    logic [31:0]     ins;
    logic            ins_ack;
    logic            wb_valid;
    logic [4:0]      wb_rd;
    logic [31:0]     wb_data;
    logic            ins_illegal;

    logic [31:0] lfsr = 32'd72;    // seed
    logic [31:0] ref_regs [32];    // reference register model
    int          cyc = 0;
    int          errors = 0;
    int          tests = 0;
    int          test_err0 = 0;
    // expected outcomes, in issue order
    int          due_q [$];
    bit          ill_q [$];
    logic [4:0]  rd_q [$];
    logic [31:0] data_q [$];

    exec_pipe #(.NUM_REGS(NUM_REGS)) DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    always @(posedge clk) cyc <= cyc + 1;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(1 + (rand_bits(5) % (NUM_REGS - 1)));   // x1 upward, in range
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    // rv32i semantics, updates the model for legal writes to x1 and up
    task automatic ref_apply(input logic [31:0] w, output bit legal,
        output logic [4:0] rd, output logic [31:0] val);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        opc = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        rd = w[11:7];
        a = ref_regs[w[19:15]];
        b = ref_regs[w[24:20]];
        val = '0;
        legal = (int'(rd) < NUM_REGS);
        if (opc == OPC_OP)
        begin
            legal &= (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            legal &= int'(w[19:15]) < NUM_REGS && int'(w[24:20]) < NUM_REGS;
        end
        else if (opc == OPC_OP_IMM)
        begin
            b = {{20{w[31]}}, w[31:20]};
            if (f3 == 3'd1)
                legal &= (f7 == 7'h00);
            else if (f3 == 3'd5)
                legal &= (f7 == 7'h00 || f7 == 7'h20);
            legal &= int'(w[19:15]) < NUM_REGS;
        end
        else if (opc != OPC_LUI)
            legal = 1'b0;
        if (opc == OPC_LUI)
            val = {w[31:12], 12'h000};
        else
        begin
            case (f3)
                3'd0: val = (opc == OPC_OP && f7 == 7'h20) ? a - b : a + b;
                3'd1: val = a << b[4:0];
                3'd2: val = {31'd0, $signed(a) < $signed(b)};
                3'd3: val = {31'd0, a < b};
                3'd4: val = a ^ b;
                3'd5: val = (f7 == 7'h20) ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'd6: val = a | b;
                default: val = a & b;
            endcase
        end
        if (legal && rd != 5'd0)
            ref_regs[rd] = val;
    endtask

    task automatic wait_ack(input logic level);
        for (int t = 0; t < 40; t++)
        begin
            @(posedge clk);
            #0.5;
            if (ins_ack === level)
                return;
        end
        $display("timeout waiting for ack to reach %0d", level);
        $display("Testbench failed");
        $finish;
    endtask

    // record the expectation, then one fast four-phase handshake
    task automatic issue(input logic [31:0] w, input int hold = 0);
        bit          legal;
        logic [4:0]  rd;
        logic [31:0] val;
        ref_apply(w, legal, rd, val);
        due_q.push_back(cyc + (legal ? 3 : 2));
        ill_q.push_back(!legal);
        rd_q.push_back(rd);
        data_q.push_back(val);
        ins = w;
        ins_req = 1'b1;
        wait_ack(1'b1);
        repeat (hold)
        begin
            @(posedge clk);
            #0.5;
            assert (ins_ack) else
            begin
                $display("ack dropped while req held");
                errors++;
            end
        end
        ins_req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-12s done, %0d errors", name, errors - test_err0);
        test_err0 = errors;
    endtask

    // outputs compared mid-cycle against the expected queue
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (due_q.size() > 0 && due_q[0] == cyc)
            begin
                if (ill_q[0])
                begin
                    assert (ins_illegal && !wb_valid) else
                    begin
                        $display("illegal pulse missing or retire seen at cycle %0d", cyc);
                        errors++;
                    end
                end
                else
                begin
                    assert (wb_valid && !ins_illegal) else
                    begin
                        $display("retire missing at cycle %0d", cyc);
                        errors++;
                    end
                    assert (wb_rd == rd_q[0]) else
                    begin
                        $display("ERR wb_rd exp %h got %h", rd_q[0], wb_rd);
                        errors++;
                    end
                    assert (wb_data == data_q[0]) else
                    begin
                        $display("ERR wb_data exp %h got %h", data_q[0], wb_data);
                        errors++;
                    end
                end
                void'(due_q.pop_front());
                void'(ill_q.pop_front());
                void'(rd_q.pop_front());
                void'(data_q.pop_front());
            end
            else
            begin
                assert (!wb_valid && !ins_illegal) else
                begin
                    $display("unexpected retire or illegal at cycle %0d", cyc);
                    errors++;
                end
            end
        end
    end

    initial
    begin
        logic [2:0]  f3;
        logic [4:0]  rd;
        ins_req = 1'b0;
        ins = '0;
        rst = 1'b1;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = '0;
        repeat (10) @(posedge clk);
        #0.5;
        rst = 1'b0;
        // control outputs quiet after reset
        assert (!ins_ack && !wb_valid && !ins_illegal && !DUT.acc_valid && !DUT.dec_valid) else
        begin
            $display("control output high after reset");
            errors++;
        end
        end_test("reset");

        // random register contents
        for (int r = 1; r < NUM_REGS; r++)
        begin
            issue({20'(rand_bits(20)), 5'(r), OPC_LUI});
            issue(enc_i(12'(rand_bits(12)), 5'(r), 3'd4, 5'(r)));
        end
        // operands of opposite sign for the compares and sra
        issue({20'h80001, 5'd1, OPC_LUI});
        issue(enc_i(12'h005, 5'd0, 3'd0, 5'd2));
        for (int k = 0; k < 4; k++)
        begin
            issue(enc_r(7'h00, 5'd2, 5'd1, 3'd2, rand_reg()));
            issue(enc_r(7'h00, 5'd2, 5'd1, 3'd3, rand_reg()));
            issue(enc_r(7'h20, 5'd2, 5'd1, 3'd5, rand_reg()));
            issue(enc_r(7'h00, 5'd1, 5'd2, 3'd2, rand_reg()));
            issue({20'h80001, 5'd1, OPC_LUI});
        end
        for (int k = 0; k < 40; k++)
        begin
            f3 = 3'(rand_bits(3));
            issue(enc_r((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) ? 7'h20 : 7'h00,
                rand_reg(), rand_reg(), f3, rand_reg()));
        end
        end_test("reg_reg");

        for (int k = 0; k < 40; k++)
        begin
            f3 = 3'(rand_bits(3));
            if (f3 == 3'd1)
                issue(enc_i({7'h00, 5'(rand_bits(5))}, rand_reg(), f3, rand_reg()));
            else if (f3 == 3'd5)
                issue(enc_i({rand_bits(1) ? 7'h20 : 7'h00, 5'(rand_bits(5))},
                    rand_reg(), f3, rand_reg()));
            else
                issue(enc_i(12'(rand_bits(12)), rand_reg(), f3, rand_reg()));
            if (k % 8 == 0)
                issue({20'(rand_bits(20)), rand_reg(), OPC_LUI});
        end
        end_test("imm_lui");

        // each instruction reads the previous destination
        rd = rand_reg();
        issue(enc_i(12'(rand_bits(12)), 5'd0, 3'd0, rd));
        for (int k = 0; k < 30; k++)
        begin
            f3 = 3'(rand_bits(3));
            if (f3 == 3'd1 || f3 == 3'd5)
                f3 = 3'd0;
            if (k % 2 == 0)
                issue(enc_r(7'h00, rd, rd, f3, rand_reg()));
            else
                issue(enc_i(12'(rand_bits(12)), rd, f3, rand_reg()));
            rd = ins[11:7];
        end
        end_test("chain");

        issue(enc_i(12'h123, 5'd1, 3'd0, 5'd0));   // retires, not stored
        issue(enc_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd3));
        issue(enc_i(12'h7ff, 5'd0, 3'd0, 5'd0));
        issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd4));
        end_test("x0");

        issue({25'h0000abc, 7'b0000011});               // load opcode
        issue({25'h1234567, 7'b1100011});               // branch opcode
        issue(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd5));    // m extension
        issue(enc_r(7'h20, 5'd2, 5'd1, 3'd4, 5'd5));
        issue(enc_i({7'h20, 5'd3}, 5'd1, 3'd1, 5'd5));
        issue(enc_i({7'h10, 5'd3}, 5'd1, 3'd5, 5'd5));
        if (NUM_REGS == 16)
        begin
            issue(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd17));
            issue(enc_r(7'h00, 5'd20, 5'd1, 3'd0, 5'd5));
            issue(enc_i(12'h001, 5'd31, 3'd0, 5'd5));
            issue({20'h12345, 5'd16, OPC_LUI});
        end
        issue(enc_r(7'h00, 5'd0, 5'd5, 3'd0, 5'd6));    // x5 left unchanged
        end_test("illegal");

        issue(enc_i(12'h321, 5'd2, 3'd0, 5'd7), 6);     // held req, one capture
        issue(enc_r(7'h00, 5'd7, 5'd7, 3'd0, 5'd8), 3);
        end_test("handshake");

        for (int t = 0; t < 20 && due_q.size() > 0; t++)
            @(posedge clk);
        repeat (3) @(posedge clk);
        if (due_q.size() > 0)
        begin
            $display("expected outcomes never arrived");
            errors++;
        end
        errors += DUT.u_checker.fail_count;   // bound assertion failures
        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule : exec_pipe_tb

/* source/alu_exec.sv */
`timescale 1ns/100ps

module alu_exec
    import rv_exec_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dec_valid,
    input  alu_op_t              dec_op,
    input  logic [XLEN-1:0]      dec_a,
    input  logic [XLEN-1:0]      dec_b,
    input  logic [REG_IDX_W-1:0] dec_rd,
    output logic                 wb_valid,  // retire strobe, also file write
    output logic [REG_IDX_W-1:0] wb_rd,
    output logic [XLEN-1:0]      wb_data
);

    logic            sub_sel;      // subtract for sub and compares
    logic [XLEN-1:0] b_op;         // b or its complement
    logic [XLEN:0]   add_sub;      // 33 bits, top is carry out
    logic            borrow;
    logic            sof;          // signed overflow of a - b
    logic [4:0]      shamt;
    logic [XLEN-1:0] shift_res;
    logic [XLEN-1:0] logic_res;
    logic [XLEN-1:0] result;

    assign sub_sel = (dec_op == ALU_SUB) || (dec_op == ALU_SLT) || (dec_op == ALU_SLTU);

    // a + ~b + 1 when subtracting
    assign b_op    = sub_sel ? ~dec_b : dec_b;
    assign add_sub = {1'b0, dec_a} + {1'b0, b_op} + {{XLEN{1'b0}}, sub_sel};
    assign borrow  = ~add_sub[XLEN];    // no carry out means a < b unsigned
    assign sof     = (dec_a[XLEN-1] ^ dec_b[XLEN-1])
                   & (dec_a[XLEN-1] ^ add_sub[XLEN-1]);

    assign shamt = dec_b[4:0];  // low five bits only

    always_comb
    begin
        case (dec_op)
            ALU_SRL: shift_res = dec_a >> shamt;
            ALU_SRA: shift_res = $signed(dec_a) >>> shamt;  // sign fill
            default: shift_res = dec_a << shamt;
        endcase
    end

    always_comb
    begin
        case (dec_op)
            ALU_XOR: logic_res = dec_a ^ dec_b;
            ALU_AND: logic_res = dec_a & dec_b;
            default: logic_res = dec_a | dec_b;
        endcase
    end

    // final result mux
    always_comb
    begin
        case (dec_op)
            ALU_ADD,
            ALU_SUB:  result = add_sub[XLEN-1:0];
            ALU_SLL,
            ALU_SRL,
            ALU_SRA:  result = shift_res;
            ALU_XOR,
            ALU_OR,
            ALU_AND:  result = logic_res;
            ALU_SLT:  result = {{(XLEN - 1){1'b0}}, add_sub[XLEN-1] ^ sof};
            ALU_SLTU: result = {{(XLEN - 1){1'b0}}, borrow};
            default:  result = add_sub[XLEN-1:0];
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            wb_valid <= 1'b0;
        else
            wb_valid <= dec_valid;
    end

    // execute result register
    always_ff @(posedge clk)
    begin
        wb_rd   <= dec_rd;
        wb_data <= result;  // x0 writes still report data
    end

endmodule : alu_exec

/* source/exec_pipe.sv */
`timescale 1ns/100ps

module exec_pipe
    import rv_exec_pkg::*;
#(
    parameter int NUM_REGS = 32     // 16 gives rv32e
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ins_req,
    input  logic [ILEN-1:0]      ins,
    output logic                 ins_ack,
    output logic                 wb_valid,     // retire report
    output logic [REG_IDX_W-1:0] wb_rd,
    output logic [XLEN-1:0]      wb_data,
    output logic                 ins_illegal
);

    // accept -> decode
    logic                 acc_valid;
    logic [ILEN-1:0]      acc_ins;

    // decode <-> register file
    logic [REG_IDX_W-1:0] rs1_idx;
    logic [REG_IDX_W-1:0] rs2_idx;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      rs2_data;

    // decode -> execute
    logic                 dec_valid;
    alu_op_t              dec_op;
    logic [XLEN-1:0]      dec_a;
    logic [XLEN-1:0]      dec_b;
    logic [REG_IDX_W-1:0] dec_rd;

    instr_accept u_accept (
        .clk, .rst,
        .ins_req, .ins, .ins_ack,
        .acc_valid, .acc_ins
    );

    // execute output register doubles as the forwarding source
    instr_decode #(.NUM_REGS(NUM_REGS)) u_decode (
        .clk, .rst,
        .acc_valid, .acc_ins,
        .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
        .ex_valid (wb_valid),
        .ex_rd    (wb_rd),
        .ex_data  (wb_data),
        .dec_valid, .dec_op, .dec_a, .dec_b, .dec_rd,
        .ins_illegal
    );

    reg_file #(.NUM_REGS(NUM_REGS)) u_regs (
        .clk, .rst,
        .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
        .we      (wb_valid),   // writeback at the edge after retire
        .wr_idx  (wb_rd),
        .wr_data (wb_data)
    );

    alu_exec u_alu (
        .clk, .rst,
        .dec_valid, .dec_op, .dec_a, .dec_b, .dec_rd,
        .wb_valid, .wb_rd, .wb_data
    );

endmodule : exec_pipe

/* source/instr_accept.sv */
`timescale 1ns/100ps

module instr_accept
    import rv_exec_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            ins_req,    // four-phase request from producer
    input  logic [ILEN-1:0] ins,        // stable while req high
    output logic            ins_ack,
    output logic            acc_valid,  // one-cycle pulse per capture
    output logic [ILEN-1:0] acc_ins
);

    // handshake states
    typedef enum logic {
        ST_IDLE  = 1'b0,    // waiting for req
        ST_ACKED = 1'b1     // ack high, waiting for req to drop
    } acc_state_t;

    acc_state_t state;

    assign ins_ack = (state == ST_ACKED);   // ack straight from state

    // handshake fsm
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= ST_IDLE;
            acc_valid <= 1'b0;
        end
        else
        begin
            acc_valid <= 1'b0;  // pulse by default low
            case (state)
                ST_IDLE:
                begin
                    if (ins_req)
                    begin
                        state     <= ST_ACKED;
                        acc_valid <= 1'b1;  // new request seen
                    end
                end
                ST_ACKED:
                begin
                    // held-high req stays here, no second capture
                    if (!ins_req)
                        state <= ST_IDLE;   // ack drops next cycle
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // instruction word, captured on the accepting edge only
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && ins_req)
            acc_ins <= ins;
    end

endmodule : instr_accept

/* source/instr_decode.sv */
`timescale 1ns/100ps

module instr_decode
    import rv_exec_pkg::*;
#(
    parameter int NUM_REGS = 32
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 acc_valid,
    input  logic [ILEN-1:0]      acc_ins,
    output logic [REG_IDX_W-1:0] rs1_idx,   // to register file
    output logic [REG_IDX_W-1:0] rs2_idx,
    input  logic [XLEN-1:0]      rs1_data,
    input  logic [XLEN-1:0]      rs2_data,
    input  logic                 ex_valid,  // execute output register
    input  logic [REG_IDX_W-1:0] ex_rd,
    input  logic [XLEN-1:0]      ex_data,
    output logic                 dec_valid,
    output alu_op_t              dec_op,
    output logic [XLEN-1:0]      dec_a,
    output logic [XLEN-1:0]      dec_b,
    output logic [REG_IDX_W-1:0] dec_rd,
    output logic                 ins_illegal
);

    // index limit, one bit wider so 32 fits
    localparam logic [REG_IDX_W:0] REG_LIMIT = (REG_IDX_W + 1)'(NUM_REGS);

    opcode_t              opcode;
    logic [FUNCT3_W-1:0]  funct3;
    logic [FUNCT7_W-1:0]  funct7;
    logic [REG_IDX_W-1:0] rd;
    logic [SHAMT_W-1:0]   shamt;
    logic [XLEN-1:0]      imm_i;
    logic [XLEN-1:0]      imm_u;
    logic [XLEN-1:0]      rs1_val;      // after forwarding
    logic [XLEN-1:0]      rs2_val;
    alu_op_t              base_op;      // funct3 mapping, funct7 = base
    alu_op_t              op_nxt;
    logic [XLEN-1:0]      a_nxt;
    logic [XLEN-1:0]      b_nxt;
    logic                 bad_enc;
    logic                 uses_rs1;
    logic                 uses_rs2;
    logic                 idx_bad;

    // instruction fields
    assign opcode  = opcode_t'(acc_ins[6:0]);
    assign rd      = acc_ins[11:7];
    assign funct3  = acc_ins[14:12];
    assign rs1_idx = acc_ins[19:15];
    assign rs2_idx = acc_ins[24:20];
    assign funct7  = acc_ins[31:25];
    assign shamt   = acc_ins[24:20];
    assign imm_i   = {{20{acc_ins[31]}}, acc_ins[31:20]};  // sign extended
    assign imm_u   = {acc_ins[31:12], 12'b0};

    // execute result wins over file value, never for x0
    assign rs1_val = (ex_valid && ex_rd != '0 && ex_rd == rs1_idx) ? ex_data : rs1_data;
    assign rs2_val = (ex_valid && ex_rd != '0 && ex_rd == rs2_idx) ? ex_data : rs2_data;

    always_comb
    begin
        case (funct3)
            F3_ADD:  base_op = ALU_ADD;
            F3_SLL:  base_op = ALU_SLL;
            F3_SLT:  base_op = ALU_SLT;
            F3_SLTU: base_op = ALU_SLTU;
            F3_XOR:  base_op = ALU_XOR;
            F3_SR:   base_op = ALU_SRL;
            F3_OR:   base_op = ALU_OR;
            F3_AND:  base_op = ALU_AND;
            default: base_op = ALU_ADD;
        endcase
    end

    // op select, operand select and encoding check
    always_comb
    begin
        op_nxt   = base_op;
        a_nxt    = rs1_val;
        b_nxt    = imm_i;
        bad_enc  = 1'b0;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        case (opcode)
            OPC_OP:
            begin
                uses_rs2 = 1'b1;
                b_nxt    = rs2_val;
                if (funct7 == F7_ALT)
                begin
                    if (funct3 == F3_ADD)
                        op_nxt = ALU_SUB;
                    else if (funct3 == F3_SR)
                        op_nxt = ALU_SRA;
                    else
                        bad_enc = 1'b1;
                end
                else if (funct7 != F7_BASE)
                    bad_enc = 1'b1;
            end
            OPC_OP_IMM:
            begin
                if (funct3 == F3_SLL || funct3 == F3_SR)
                begin
                    b_nxt = {{(XLEN - SHAMT_W){1'b0}}, shamt};    // shamt, not imm
                    if (funct3 == F3_SR && funct7 == F7_ALT)
                        op_nxt = ALU_SRA;
                    else if (funct7 != F7_BASE)
                        bad_enc = 1'b1;   // only srai may set bit 30
                end
            end
            OPC_LUI:
            begin
                op_nxt   = ALU_ADD;   // 0 + upper immediate
                a_nxt    = '0;
                b_nxt    = imm_u;
                uses_rs1 = 1'b0;
            end
            default: bad_enc = 1'b1;  // unsupported major opcode
        endcase
    end

    // indices past the configured file size, only those actually used
    assign idx_bad = ({1'b0, rd} >= REG_LIMIT)
                   || (uses_rs1 && {1'b0, rs1_idx} >= REG_LIMIT)
                   || (uses_rs2 && {1'b0, rs2_idx} >= REG_LIMIT);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            dec_valid   <= 1'b0;
            ins_illegal <= 1'b0;
        end
        else
        begin
            dec_valid   <= acc_valid && !(bad_enc || idx_bad);
            ins_illegal <= acc_valid && (bad_enc || idx_bad);  // pulse, no retire
        end
    end

    // decoded payload
    always_ff @(posedge clk)
    begin
        dec_op <= op_nxt;
        dec_a  <= a_nxt;
        dec_b  <= b_nxt;
        dec_rd <= rd;
    end

endmodule : instr_decode

/* source/reg_file.sv */
`timescale 1ns/100ps

module reg_file
    import rv_exec_pkg::*;
#(
    parameter int NUM_REGS = 32
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [REG_IDX_W-1:0] rs1_idx,
    input  logic [REG_IDX_W-1:0] rs2_idx,
    output logic [XLEN-1:0]      rs1_data,
    output logic [XLEN-1:0]      rs2_data,
    input  logic                 we,        // from retire
    input  logic [REG_IDX_W-1:0] wr_idx,
    input  logic [XLEN-1:0]      wr_data
);

    localparam int ADDR_W = $clog2(NUM_REGS);   // 5 for rv32i, 4 for rv32e

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wr_ok;    // nonzero, in range

    assign wr_ok = we && wr_idx != '0 && int'(wr_idx) < NUM_REGS;

    // x0 and out-of-range read as zero, same-cycle write passes through
    assign rs1_data = (rs1_idx == '0 || int'(rs1_idx) >= NUM_REGS) ? '0
                    : (wr_ok && wr_idx == rs1_idx) ? wr_data
                    : regs[rs1_idx[ADDR_W-1:0]];
    assign rs2_data = (rs2_idx == '0 || int'(rs2_idx) >= NUM_REGS) ? '0
                    : (wr_ok && wr_idx == rs2_idx) ? wr_data
                    : regs[rs2_idx[ADDR_W-1:0]];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;   // whole file cleared
        end
        else if (wr_ok)
            regs[wr_idx[ADDR_W-1:0]] <= wr_data;
    end

endmodule : reg_file

/* source/rv_exec_pkg.sv */
package rv_exec_pkg;

    // data and instruction widths
    localparam int XLEN      = 32;
    localparam int ILEN      = 32;
    localparam int REG_IDX_W = 5;   // x0..x31 index field

    // instruction field widths
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;
    localparam int SHAMT_W  = 5;    // rv32 shift amount

    // funct3 encodings shared by OP and OP-IMM
    localparam logic [FUNCT3_W-1:0] F3_ADD  = 3'b000;  // add/sub/addi
    localparam logic [FUNCT3_W-1:0] F3_SLL  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT  = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SR   = 3'b101;  // srl/sra
    localparam logic [FUNCT3_W-1:0] F3_OR   = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND  = 3'b111;

    // funct7 values, base and alternate (sub, sra)
    localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000;

    // alu operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    // major opcodes, risc-v encodings
    typedef enum logic [OPCODE_W-1:0] {
        OPC_OP     = 7'b0110011,    // register-register
        OPC_OP_IMM = 7'b0010011,    // register-immediate
        OPC_LUI    = 7'b0110111     // load upper immediate
    } opcode_t;

endpackage : rv_exec_pkg
